/* cdc_pg_pkg.sv */
/*
 * CDC power-gating clock-side package
 * Shared status, control and output bundles that pass between the
 * synchronizer bank, the gate policy and the clock request logic
 */
`default_nettype none

package cdc_pg_pkg;

    // Flops in every pgcb_clk synchronizer chain
    localparam int sync_stages_p = 2;

    // ------------------------------
    // Main clock domain status, raw and synchronized copies share this type
    typedef struct packed {
        logic domain_locked;       // Boundary and ISM locked in main domain
        logic force_ready;         // Domain may be forced into power gating
        logic clkreq_hold;         // Main domain is holding the clock request
        logic ism_wake;            // Fabric ISM left idle while locked
        logic domain_pok;          // Power OK as seen by the main domain
        logic ism_locked;          // ISM lock state from the main domain
        logic clkreq_start_hold;   // Main FSM is waiting for clkack to drop
    } main_status_t;

    // Aggregation controls, already in pgcb_clk
    typedef struct packed {
        logic pwrgate_disabled;    // Idle-based gating not allowed
        logic pwrgate_force;       // Force the domain to gate and lock
        logic pwrgate_pmc_wake;    // PMC wants the domain awake
    } pg_ctrl_t;

    // PGCB handshake inputs, pgcb_clk
    typedef struct packed {
        logic force_rst_b;         // Active low forced reset
        logic pwrgate_active;      // Power gating has been applied
        logic pok;                 // PGCB power OK
        logic restore;             // PGCB restore phase in progress
    } pgcb_if_t;

    // ------------------------------
    // Registered indications sent back to the main domain
    typedef struct packed {
        logic unlock_domain;
        logic assert_clkreq;
        logic pwrgate_active;
        logic cdc_restore;
        logic force_pgate_req;
        logic ism_locked;
        logic clkreq_start_hold_ack;
    } to_main_t;

    // Wake sources after synchronization
    typedef struct packed {
        logic gclock_req_sync;     // Synced gated-clock request
        logic gclock_req_async_or; // OR of all synced async requests
    } wake_t;

endpackage : cdc_pg_pkg

`default_nettype wire

/* cdc_pg_sync_bank.sv */
/*
 * Synchronizer bank
 * Brings main-domain status, clkack and all gated-clock wake requests
 * into pgcb_clk and flops the OR of the async requests once more
 */
`timescale 1ns/100ps
`default_nettype none

module cdc_pg_sync_bank
    import cdc_pg_pkg::*;
#(
    parameter int areq      = 1,       // Number of async gclock requests
    parameter bit def_pwron = 1'b1     // Powered-on state after reset
) (
    input  wire logic               pgcb_clk,
    input  wire logic               pgcb_reset_b,
    input  wire main_status_t       main_status,       // Async to pgcb_clk
    input  wire logic               clkack,
    input  wire logic               gclock_req_sync,   // Not glitch free
    input  wire logic [areq-1:0]    gclock_req_async,  // Glitch free requests
    output main_status_t            main_status_pg,
    output logic                    clkack_pg,
    output wake_t                   wake_pg,
    output logic                    gclock_req_async_or_pg
);

    // All bits cross as one vector, status on top and async bits at the bottom
    localparam int width_c = $bits(main_status_t) + 2 + areq;

    // Lock and hold indications come out of reset set when powered on
    localparam main_status_t status_rst_c = '{
        domain_locked     : def_pwron,
        force_ready       : 1'b0,
        clkreq_hold       : def_pwron,
        ism_wake          : 1'b0,
        domain_pok        : 1'b0,
        ism_locked        : def_pwron,
        clkreq_start_hold : 1'b0
    };
    localparam logic [width_c-1:0] sync_rst_c = {status_rst_c, 2'b00, {areq{1'b0}}};

    logic [width_c-1:0] sync_d;
    logic [width_c-1:0] sync_q [sync_stages_p];    // Stage 0 may go metastable
    logic [areq-1:0]    async_bits;                // Synced async requests

    assign sync_d = {main_status, clkack, gclock_req_sync, gclock_req_async};

    always_ff @(posedge pgcb_clk, negedge pgcb_reset_b) begin
        if (!pgcb_reset_b) begin
            for (int s = 0; s < sync_stages_p; s++) begin
                sync_q[s] <= sync_rst_c;
            end
        end else begin
            sync_q[0] <= sync_d;
            for (int s = 1; s < sync_stages_p; s++) begin
                sync_q[s] <= sync_q[s-1];          // Shift toward the last stage
            end
        end
    end

    // Split the last stage back into its named parts
    assign {main_status_pg, clkack_pg, wake_pg.gclock_req_sync, async_bits} =
        sync_q[sync_stages_p-1];

    assign wake_pg.gclock_req_async_or = |async_bits;

    // One more flop so the OR leaving this block is glitch free
    always_ff @(posedge pgcb_clk, negedge pgcb_reset_b) begin
        if (!pgcb_reset_b) begin
            gclock_req_async_or_pg <= 1'b0;
        end else begin
            gclock_req_async_or_pg <= wake_pg.gclock_req_async_or;
        end
    end

endmodule : cdc_pg_sync_bank

`default_nettype wire

/* cdc_pg_gate_ctl.sv */
/*
 * Power-gate policy
 * Decides readiness for gating, unlock of the domain, forced gate
 * requests, PMC wake masking and the restore indication
 */
`timescale 1ns/100ps
`default_nettype none

module cdc_pg_gate_ctl
    import cdc_pg_pkg::*;
#(
    parameter bit def_pwron = 1'b1
) (
    input  wire logic          pgcb_clk,
    input  wire logic          pgcb_reset_b,
    input  wire main_status_t  main_status_pg,   // Synced main-domain status
    input  wire wake_t         wake_pg,
    input  wire pg_ctrl_t      pg_ctrl,
    input  wire pgcb_if_t      pgcb,
    output logic               unlock_domain,
    output logic               cdc_restore,
    output logic               force_pgate_req,
    output logic               pmc_wake,
    output logic               pwrgate_ready
);

    logic restore_wake;          // Wake created by a restore, held until unlocked
    logic any_wake;
    logic locked;
    logic unlock_domain_next;
    logic cdc_restore_next;
    logic force_pgate_req_next;
    logic pmc_wake_next;
    logic restore_wake_next;

    assign locked   = main_status_pg.domain_locked;
    assign any_wake = wake_pg.gclock_req_sync | wake_pg.gclock_req_async_or |
                      main_status_pg.ism_wake;

    // ------------------------------
    // Gate readiness
    always_comb begin
        if (pmc_wake) begin
            pwrgate_ready = 1'b0;                           // PMC keeps the domain awake
        end else if (!locked || unlock_domain || !main_status_pg.ism_locked) begin
            pwrgate_ready = 1'b0;                           // Only a fully locked domain may gate
        end else if (pg_ctrl.pwrgate_force) begin
            pwrgate_ready = main_status_pg.force_ready;     // Wait for the main domain to agree
        end else if (!pgcb.pok) begin
            pwrgate_ready = 1'b1;                           // Already gated, stay there
        end else begin
            // Powered and locked, gate unless something wants the clock
            pwrgate_ready = !(any_wake | pg_ctrl.pwrgate_disabled | pgcb.restore |
                              cdc_restore | restore_wake);
        end
    end

    // ------------------------------
    // Unlock decision
    always_comb begin
        if (unlock_domain && locked) begin
            unlock_domain_next = 1'b1;                      // Finish an unlock in progress
        end else if (pgcb.pwrgate_active || !pgcb.force_rst_b) begin
            unlock_domain_next = 1'b0;
        end else if (force_pgate_req && main_status_pg.ism_locked) begin
            unlock_domain_next = 1'b0;                      // Forced gating outside a restore
        end else if (!pgcb.pok || !locked) begin
            unlock_domain_next = 1'b0;
        end else begin
            unlock_domain_next = any_wake | pg_ctrl.pwrgate_disabled | restore_wake;
        end
    end

    // After a restore the FSM has to leave RESTORE, so a restore turns into
    // a wake that lasts until the domain is unlocked
    always_comb begin
        if (!locked) begin
            restore_wake_next = 1'b0;
        end else begin
            restore_wake_next = cdc_restore | restore_wake;
        end
    end

    // Restore only starts on a locked ISM and is cut short by a force request
    always_comb begin
        if (cdc_restore && !force_pgate_req) begin
            cdc_restore_next = main_status_pg.ism_locked ? 1'b1 : pgcb.restore;
        end else begin
            cdc_restore_next = pgcb.restore & main_status_pg.ism_locked;
        end
    end

    // ------------------------------
    // Force and PMC wake mask each other, the registered one wins
    always_comb begin
        if (!force_pgate_req) begin
            // No new force while unlocking or while PMC wake is arriving
            force_pgate_req_next = pg_ctrl.pwrgate_force & !unlock_domain_next &
                                   !pg_ctrl.pwrgate_pmc_wake;
        end else begin
            force_pgate_req_next = pg_ctrl.pwrgate_force;
        end

        if (!pmc_wake) begin
            pmc_wake_next = pg_ctrl.pwrgate_pmc_wake & !force_pgate_req;
        end else begin
            pmc_wake_next = pg_ctrl.pwrgate_pmc_wake;
        end
    end

    always_ff @(posedge pgcb_clk, negedge pgcb_reset_b) begin
        if (!pgcb_reset_b) begin
            unlock_domain   <= 1'b0;
            cdc_restore     <= def_pwron;
            restore_wake    <= def_pwron;
            force_pgate_req <= 1'b0;
            pmc_wake        <= 1'b0;
        end else begin
            unlock_domain   <= unlock_domain_next;
            cdc_restore     <= cdc_restore_next;
            restore_wake    <= restore_wake_next;
            force_pgate_req <= force_pgate_req_next;
            pmc_wake        <= pmc_wake_next;
        end
    end

endmodule : cdc_pg_gate_ctl

`default_nettype wire

/* cdc_pg_clkreq_ctl.sv */
/*
 * Functional clock request control
 * Starts, holds and releases clkreq, and waits for clkack to drop
 * before a new request is allowed
 */
`timescale 1ns/100ps
`default_nettype none

module cdc_pg_clkreq_ctl
    import cdc_pg_pkg::*;
#(
    parameter bit def_pwron = 1'b1,
    parameter bit drive_pok = 1'b1     // Domain drives its own POK
) (
    input  wire logic          pgcb_clk,
    input  wire logic          pgcb_reset_b,
    input  wire main_status_t  main_status_pg,
    input  wire logic          clkack_pg,
    input  wire wake_t         wake_pg,
    input  wire logic          pwrgate_disabled,
    input  wire logic          pok,
    input  wire logic          restore,
    input  wire logic          unlock_domain,
    input  wire logic          force_pgate_req,
    input  wire logic          pmc_wake,
    output logic               clkreq,
    output logic               assert_clkreq,
    output logic               clkreq_start_hold_ack
);

    logic assert_clkreq_next;
    logic clkreq_start_ok;       // clkack seen low since the last hold
    logic hold;
    logic locked;
    logic any_wake;

    assign hold     = main_status_pg.clkreq_hold;
    assign locked   = main_status_pg.domain_locked;
    assign any_wake = wake_pg.gclock_req_sync | wake_pg.gclock_req_async_or |
                      main_status_pg.ism_wake;

    // The synced start-hold is the acknowledge back to the main FSM
    assign clkreq_start_hold_ack = main_status_pg.clkreq_start_hold;

    // ------------------------------
    always_comb begin
        assert_clkreq_next = 1'b0;
        if (!assert_clkreq && hold) begin
            assert_clkreq_next = 1'b0;                          // Main domain owns the request
        end else if (assert_clkreq) begin
            if (pmc_wake && drive_pok && !main_status_pg.domain_pok) begin
                assert_clkreq_next = 1'b1;                      // Clock needed to raise POK
            end else if ((any_wake || pwrgate_disabled || unlock_domain) && locked &&
                         !force_pgate_req) begin
                assert_clkreq_next = 1'b1;                      // Keep going until unlocked
            end else begin
                assert_clkreq_next = !hold;                     // Release once the hold is seen
            end
        end else if (clkreq_start_ok) begin
            // Things that may start a new request
            if (!pok && !main_status_pg.domain_pok) begin
                assert_clkreq_next = pmc_wake && drive_pok;
            end else if (force_pgate_req) begin
                assert_clkreq_next = 1'b1;                      // Clock runs to lock and drop POK
            end else if (any_wake || restore) begin
                assert_clkreq_next = 1'b1;
            end else if (locked == pwrgate_disabled) begin
                // Lock state disagrees with the gating policy, wake to reconcile
                assert_clkreq_next = 1'b1;
            end
        end
    end

    always_ff @(posedge pgcb_clk, negedge pgcb_reset_b) begin
        if (!pgcb_reset_b) begin
            assert_clkreq   <= 1'b0;
            clkreq          <= def_pwron;
            clkreq_start_ok <= !def_pwron;
        end else begin
            assert_clkreq   <= assert_clkreq_next;
            clkreq          <= hold | assert_clkreq_next;
            // No restart until clkack has dropped after the hold ends
            clkreq_start_ok <= hold ? 1'b0 :
                               (clkreq_start_ok | (!clkack_pg & !clkreq_start_hold_ack));
        end
    end

endmodule : cdc_pg_clkreq_ctl

`default_nettype wire

/* cdc_pg_clock.sv */
/*
 * CDC power-gating controller, pgcb_clk side
 * Top level that ties synchronizers, gate policy and clock request
 * together and registers the indications sent to the main domain
 */
`timescale 1ns/100ps
`default_nettype none

module cdc_pg_clock
    import cdc_pg_pkg::*;
#(
    parameter int areq      = 1,
    parameter bit def_pwron = 1'b1,
    parameter bit drive_pok = 1'b1
) (
    input  wire logic               pgcb_clk,          // Always running
    input  wire logic               pgcb_reset_b,
    input  wire logic               clkack,
    input  wire main_status_t       main_status,
    input  wire logic               gclock_req_sync,
    input  wire logic [areq-1:0]    gclock_req_async,
    input  wire pg_ctrl_t           pg_ctrl,
    input  wire pgcb_if_t           pgcb,
    output logic                    clkreq,
    output to_main_t                to_main,
    output logic                    gclock_req_async_or_pg,
    output logic                    pwrgate_ready
);

    main_status_t main_status_pg;
    wake_t        wake_pg;
    logic         clkack_pg;
    logic         unlock_domain;
    logic         cdc_restore;
    logic         force_pgate_req;
    logic         pmc_wake;
    logic         assert_clkreq;
    logic         clkreq_start_hold_ack;
    logic         pwrgate_active_q;   // Clean copy before it crosses to main

    cdc_pg_sync_bank #(
        .areq      (areq),
        .def_pwron (def_pwron)
    ) i_sync_bank (
        .pgcb_clk               (pgcb_clk),
        .pgcb_reset_b           (pgcb_reset_b),
        .main_status            (main_status),
        .clkack                 (clkack),
        .gclock_req_sync        (gclock_req_sync),
        .gclock_req_async       (gclock_req_async),
        .main_status_pg         (main_status_pg),
        .clkack_pg              (clkack_pg),
        .wake_pg                (wake_pg),
        .gclock_req_async_or_pg (gclock_req_async_or_pg)
    );

    cdc_pg_gate_ctl #(
        .def_pwron (def_pwron)
    ) i_gate_ctl (
        .pgcb_clk        (pgcb_clk),
        .pgcb_reset_b    (pgcb_reset_b),
        .main_status_pg  (main_status_pg),
        .wake_pg         (wake_pg),
        .pg_ctrl         (pg_ctrl),
        .pgcb            (pgcb),
        .unlock_domain   (unlock_domain),
        .cdc_restore     (cdc_restore),
        .force_pgate_req (force_pgate_req),
        .pmc_wake        (pmc_wake),
        .pwrgate_ready   (pwrgate_ready)
    );

    cdc_pg_clkreq_ctl #(
        .def_pwron (def_pwron),
        .drive_pok (drive_pok)
    ) i_clkreq_ctl (
        .pgcb_clk              (pgcb_clk),
        .pgcb_reset_b          (pgcb_reset_b),
        .main_status_pg        (main_status_pg),
        .clkack_pg             (clkack_pg),
        .wake_pg               (wake_pg),
        .pwrgate_disabled      (pg_ctrl.pwrgate_disabled),
        .pok                   (pgcb.pok),
        .restore               (pgcb.restore),
        .unlock_domain         (unlock_domain),
        .force_pgate_req       (force_pgate_req),
        .pmc_wake              (pmc_wake),
        .clkreq                (clkreq),
        .assert_clkreq         (assert_clkreq),
        .clkreq_start_hold_ack (clkreq_start_hold_ack)
    );

    // pwrgate_active is flopped here so the main domain sees one clean edge
    always_ff @(posedge pgcb_clk, negedge pgcb_reset_b) begin
        if (!pgcb_reset_b) begin
            pwrgate_active_q <= 1'b1;
        end else begin
            pwrgate_active_q <= pgcb.pwrgate_active;
        end
    end

    // ------------------------------
    // Bundle toward the main domain
    assign to_main.unlock_domain         = unlock_domain;
    assign to_main.assert_clkreq         = assert_clkreq;
    assign to_main.pwrgate_active        = pwrgate_active_q;
    assign to_main.cdc_restore           = cdc_restore;
    assign to_main.force_pgate_req       = force_pgate_req;
    assign to_main.ism_locked            = main_status_pg.ism_locked;   // Echo avoids a race
    assign to_main.clkreq_start_hold_ack = clkreq_start_hold_ack;

endmodule : cdc_pg_clock

`default_nettype wire

/* tb_cdc_pg_clock.sv */
/*
 * Testbench for the pgcb_clk side of the power-gating controller
 * Checks reset values and the pwrgate_active mirror, then walks a table of
 * input rows and compares the settled outputs with the expected ones
 */
`timescale 1ns/100ps
`default_nettype none

module tb_cdc_pg_clock
    import cdc_pg_pkg::*;
();

    localparam int areq_c          = 4;    // Four async wake sources
    localparam int reset_cycles_c  = 8;
    localparam int settle_cycles_c = 8;    // Longer than the worst wake latency
    localparam int n_rows_c        = 13;
    localparam int timeout_cycles_c =
        reset_cycles_c + 8 + n_rows_c * (settle_cycles_c + 2) + 50;

    // One stimulus row with its expected outputs
    typedef struct packed {
        main_status_t status;
        pg_ctrl_t     ctrl;
        pgcb_if_t     pgcb_in;
        logic         req_sync;
        logic         req_async;    // Set one random async bit
        logic         clkack;
        logic [5:0]   exp_v;        // clkreq, assert, ready, unlock, force, restore
    } row_t;

    logic               pgcb_clk = 1'b0;
    logic               pgcb_reset_b;
    logic               clkack;
    main_status_t       main_status;
    logic               gclock_req_sync;
    logic [areq_c-1:0]  gclock_req_async;
    pg_ctrl_t           pg_ctrl;
    pgcb_if_t           pgcb;
    logic               clkreq;
    to_main_t           to_main;
    logic               gclock_req_async_or_pg;
    logic               pwrgate_ready;

    row_t        rows [n_rows_c];
    string       row_name [n_rows_c];
    logic [16:0] lfsr_state = 17'd74887;

    always #2 pgcb_clk = ~pgcb_clk;    // 4 ns period

    cdc_pg_clock #(
        .areq      (areq_c),
        .def_pwron (1'b1),
        .drive_pok (1'b1)
    ) i_dut (
        .pgcb_clk               (pgcb_clk),
        .pgcb_reset_b           (pgcb_reset_b),
        .clkack                 (clkack),
        .main_status            (main_status),
        .gclock_req_sync        (gclock_req_sync),
        .gclock_req_async       (gclock_req_async),
        .pg_ctrl                (pg_ctrl),
        .pgcb                   (pgcb),
        .clkreq                 (clkreq),
        .to_main                (to_main),
        .gclock_req_async_or_pg (gclock_req_async_or_pg),
        .pwrgate_ready          (pwrgate_ready)
    );

    // ------------------------------
    // Fibonacci LFSR, x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic pick_async_index(output logic [1:0] idx);
        for (int b = 0; b < 2; b++) begin
            lfsr_state = lfsr_step(lfsr_state);    // One step per bit taken
            idx[b]     = lfsr_state[0];
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error: %s expected %0b actual %0b", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_reset_values(input string when);
        check_bit({when, " clkreq"}, 1'b1, clkreq);
        check_bit({when, " pwrgate_active"}, 1'b1, to_main.pwrgate_active);
        check_bit({when, " cdc_restore"}, 1'b1, to_main.cdc_restore);
        check_bit({when, " unlock_domain"}, 1'b0, to_main.unlock_domain);
        check_bit({when, " assert_clkreq"}, 1'b0, to_main.assert_clkreq);
        check_bit({when, " force_pgate_req"}, 1'b0, to_main.force_pgate_req);
        check_bit({when, " pwrgate_ready"}, 1'b0, pwrgate_ready);
        check_bit({when, " async_or"}, 1'b0, gclock_req_async_or_pg);
    endtask

    task automatic set_row(input int idx, input string name, input logic [6:0] status,
                           input logic [2:0] ctrl, input logic [3:0] pgcb_in,
                           input logic req_sync, input logic req_async, input logic [5:0] exp_v);
        rows[idx].status    = status;     // locked, fready, hold, iwake, dpok, ism, shold
        rows[idx].ctrl      = ctrl;       // disabled, force, pmc_wake
        rows[idx].pgcb_in   = pgcb_in;    // force_rst_b, active, pok, restore
        rows[idx].req_sync  = req_sync;
        rows[idx].req_async = req_async;
        rows[idx].clkack    = 1'b0;
        rows[idx].exp_v     = exp_v;
        row_name[idx]       = name;
    endtask

    // ------------------------------
    initial begin
        repeat (timeout_cycles_c) @(posedge pgcb_clk);
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles_c);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [1:0] async_idx;

        // Powered on, locked and idle while in reset
        pgcb_reset_b     = 1'b0;
        clkack           = 1'b0;
        main_status      = 7'b1010010;
        gclock_req_sync  = 1'b0;
        gclock_req_async = '0;
        pg_ctrl          = 3'b000;
        pgcb             = 4'b1110;

        set_row(0,  "unlocked domain requests clock", 7'b0000100, 3'b000, 4'b1010, 0, 0, 6'b110000);
        set_row(1,  "clock held by main domain",      7'b0010101, 3'b000, 4'b1010, 0, 0, 6'b100000);
        set_row(2,  "idle locked domain",             7'b1000110, 3'b000, 4'b1010, 0, 0, 6'b001000);
        set_row(3,  "async wake",                     7'b1000110, 3'b000, 4'b1010, 0, 1, 6'b110100);
        set_row(4,  "domain unlocked after async",    7'b0010100, 3'b000, 4'b1010, 0, 0, 6'b100000);
        set_row(5,  "idle again",                     7'b1000110, 3'b000, 4'b1010, 0, 0, 6'b001000);
        set_row(6,  "sync wake",                      7'b1000110, 3'b000, 4'b1010, 1, 0, 6'b110100);
        set_row(7,  "domain unlocked after sync",     7'b0010100, 3'b000, 4'b1010, 0, 0, 6'b100000);
        set_row(8,  "idle before pmc",                7'b1000110, 3'b000, 4'b1010, 0, 0, 6'b001000);
        set_row(9,  "pmc wake beats force",           7'b1000110, 3'b011, 4'b1010, 0, 0, 6'b000000);
        set_row(10, "force with force_ready",         7'b1100110, 3'b010, 4'b1010, 0, 0, 6'b111010);
        set_row(11, "force without force_ready",      7'b1000110, 3'b010, 4'b1010, 0, 0, 6'b110010);
        set_row(12, "restore on locked ism",          7'b1000110, 3'b000, 4'b1011, 0, 0, 6'b110101);

        repeat (reset_cycles_c - 1) @(posedge pgcb_clk);
        @(negedge pgcb_clk);
        check_reset_values("in reset");
        @(posedge pgcb_clk);
        pgcb_reset_b <= 1'b1;
        @(negedge pgcb_clk);
        check_reset_values("at release");

        // pwrgate_active reaches to_main one cycle later, both edges
        @(posedge pgcb_clk);
        pgcb.pwrgate_active <= 1'b0;
        @(negedge pgcb_clk);
        check_bit("mirror fall before", 1'b1, to_main.pwrgate_active);
        @(posedge pgcb_clk);
        pgcb.pwrgate_active <= 1'b1;
        @(negedge pgcb_clk);
        check_bit("mirror fall after", 1'b0, to_main.pwrgate_active);
        @(posedge pgcb_clk);
        @(negedge pgcb_clk);
        check_bit("mirror rise after", 1'b1, to_main.pwrgate_active);

        // ------------------------------
        for (int i = 0; i < n_rows_c; i++) begin
            @(posedge pgcb_clk);
            main_status     <= rows[i].status;
            pg_ctrl         <= rows[i].ctrl;
            pgcb            <= rows[i].pgcb_in;
            gclock_req_sync <= rows[i].req_sync;
            clkack          <= rows[i].clkack;
            if (rows[i].req_async) begin
                pick_async_index(async_idx);
                gclock_req_async <= {{(areq_c-1){1'b0}}, 1'b1} << async_idx;
            end else begin
                gclock_req_async <= '0;
            end
            repeat (settle_cycles_c) @(posedge pgcb_clk);
            @(negedge pgcb_clk);    // Outputs are stable away from the rising edge
            check_bit({row_name[i], " clkreq"}, rows[i].exp_v[5], clkreq);
            check_bit({row_name[i], " assert_clkreq"}, rows[i].exp_v[4], to_main.assert_clkreq);
            check_bit({row_name[i], " pwrgate_ready"}, rows[i].exp_v[3], pwrgate_ready);
            check_bit({row_name[i], " unlock_domain"}, rows[i].exp_v[2], to_main.unlock_domain);
            check_bit({row_name[i], " force_pgate_req"}, rows[i].exp_v[1],
                      to_main.force_pgate_req);
            check_bit({row_name[i], " cdc_restore"}, rows[i].exp_v[0], to_main.cdc_restore);
            // Synced status echoes and the flopped async OR follow the row inputs
            check_bit({row_name[i], " ism_locked"}, rows[i].status.ism_locked,
                      to_main.ism_locked);
            check_bit({row_name[i], " clkreq_start_hold_ack"}, rows[i].status.clkreq_start_hold,
                      to_main.clkreq_start_hold_ack);
            check_bit({row_name[i], " async_or"}, rows[i].req_async, gclock_req_async_or_pg);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : tb_cdc_pg_clock

`default_nettype wire

/* cdc_pg_clock.f */
cdc_pg_pkg.sv
cdc_pg_sync_bank.sv
cdc_pg_gate_ctl.sv
cdc_pg_clkreq_ctl.sv
cdc_pg_clock.sv
tb_cdc_pg_clock.sv

/* Makefile */
# Verilator build and run for the pgcb_clk power-gating controller
SIM   ?= verilator
TOP   ?= tb_cdc_pg_clock
LOG   ?= sim.log
FLIST ?= cdc_pg_clock.f

SRCS := $(shell cat $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) --binary --timing -f $(FLIST) --top-module $(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* TEST FAILED \*\*\*' $(LOG); then exit 1; fi
	@grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
